// File: all.f
design/ql_bus_pkg.sv
design/ql_addr_decode.sv
design/gc_shadow_ctrl.sv
design/ql_bus_mux.sv
design/ql_bus_fabric.sv
testbench/ql_bus_assert.sv
testbench/tb_clock_gen.sv
testbench/tb_ql_bus_fabric.sv

// File: testbench/tb_ql_bus_fabric.sv
/*
 * QL bus fabric testbench
 * Directed and LFSR bus cycles against a memory map model, checked each cycle
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ql_bus_fabric import ql_bus_pkg::*;
();

	localparam int N_TESTS         = 6;
	localparam int CYCLES_PER_TEST = 100;      // Worst case incl. four reset pulses
	localparam int TIMEOUT_NS      = (N_TESTS * CYCLES_PER_TEST + 100) * 20;

	// Expected DUT response for one cycle
	typedef struct packed
	{
		logic [15:0] din;
		logic        dtack;
		periph_sel_t sel;
		logic        we;
		logic        oe;
		logic [21:0] waddr;
		logic [15:0] wdata;
		logic        uds;
		logic        lds;
	} expect_t;

	logic        clk_sys;
	logic        reset;
	logic        rst_req;
	logic        ql_mode;
	ram_cfg_e    ram_cfg;
	cpu_req_t    cpu_req;
	src_data_t   src_data;
	src_ack_t    src_ack;
	logic [15:0] cpu_din;
	logic        cpu_dtack;
	sdram_req_t  sdram_req;
	periph_sel_t periph_sel;

	logic [31:0] lfsr;
	ram_cfg_e    cfg_m;                        // Size latched by the last reset
	logic        shadow_m;                     // Model of the shadow register
	logic        check_en;
	int          errors;
	int          checks;
	int          test_no;
	int          test_errors;                  // Error count when the test began
	string       test_name;

	tb_clock_gen u_clk
	(
		.rst_req (rst_req),
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	ql_bus_fabric u_dut
	(
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ram_cfg    (ram_cfg),
		.ql_mode    (ql_mode),
		.cpu_req    (cpu_req),
		.src_data   (src_data),
		.src_ack    (src_ack),
		.cpu_din    (cpu_din),
		.cpu_dtack  (cpu_dtack),
		.sdram_req  (sdram_req),
		.periph_sel (periph_sel)
	);

	// ========================================
	// Random source
	// ========================================
	function automatic logic lfsr_step();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1; // x^32+x^22+x^2+x+1
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	// ========================================
	// Memory map model
	// ========================================
	function automatic expect_t expected_outputs(input cpu_req_t req, input ram_cfg_e cfg,
		input logic slow, input logic shadow, input src_data_t src, input src_ack_t ack);
		expect_t     e;
		logic [23:0] a;
		logic        gc;
		logic        rd;
		logic        wr;
		logic        rom;
		logic        os;
		logic        io;
		logic        boot;
		logic        gc_os;
		logic        xram;
		logic        ram;
		logic        qlsd;
		logic        qlsd_rd;
		logic        sh_rd;
		logic        sh_wr;
		logic        hold;
		e = '0;
		a = {req.addr, req.lds && !req.uds};   // Odd byte only on a lower byte access
		case (cfg)
			RAM_128K:  a = a & 24'h03_FFFF;
			RAM_4096K: a = a & 24'h7F_FFFF;
			default:   a = a & 24'h0F_FFFF;
		endcase
		gc    = cfg == RAM_4096K;
		rd    = req.as && req.rw && (req.uds || req.lds);
		wr    = req.as && !req.rw && (req.uds || req.lds);
		rom   = a < 24'h01_0000;
		os    = a < 24'h00_C000;
		io    = a >= 24'h01_8000 && a < 24'h01_C000;
		boot  = gc && a >= 24'h04_0000 && a < 24'h05_0000;
		gc_os = gc && a >= 24'h40_0000 && a < 24'h41_0000;
		case (cfg)
			RAM_640K:  xram = a >= 24'h04_0000 && a < 24'h0C_0000;
			RAM_896K:  xram = a >= 24'h04_0000 && a < 24'h10_0000;
			RAM_4096K: xram = a >= 24'h04_0000 && a < 24'h40_0000;
			default:   xram = 1'b0;
		endcase
		ram = (a >= 24'h02_0000 && a < 24'h04_0000) || xram ||
			(gc && a >= 24'h01_0000 && a < 24'h01_8000) ||
			(gc && a >= 24'h01_C100 && a < 24'h02_0000); // GC RAM around the I/O page
		qlsd    = rd && (!gc || shadow) && rom && a >= 24'h00_FEE0;
		qlsd_rd = qlsd && a == 24'h00_FEE4;
		sh_rd   = rd && os && shadow;
		sh_wr   = req.as && !req.rw && os && !shadow;
		hold    = slow && ack.ram_delay_dtack;

		e.sel.qimi_sel   = (rd || wr) && a[23:8] == 16'h01BF;
		e.sel.zx8302_sel = (rd || wr) && io && !a[6] && !e.sel.qimi_sel;
		e.sel.qlsd_sel   = qlsd;
		e.sel.zx8301_ce  = io && wr && req.lds && a[6:5] == 2'b11 && a[1]; // $18063 and mirrors
		e.sel.vram_wr    = wr && a[23:16] == 8'h02;

		if (io)
			e.din = e.sel.qimi_sel ? {src.qimi, src.qimi} :
				e.sel.zx8302_sel ? src.zx8302 : 16'h0000;
		else if (qlsd_rd)
			e.din = {src.qlsd, src.qlsd};
		else if (gc && shadow && os)
			e.din = src.sdram;                 // OS copy in RAM
		else if (!gc && rom)
			e.din = src.ql_rom;
		else if (gc && !shadow && (rom || boot))
			e.din = src.gc_rom;
		else if ((gc && rom) || gc_os)
			e.din = src.ql_rom;
		else if (ram)
			e.din = src.sdram;
		else
			e.din = 16'hFFFF;

		if (qlsd)
			e.dtack = ack.qlsd_dtack;
		else if (sh_rd || sh_wr)
			e.dtack = ack.sdram_dtack;
		else if (ram)
			e.dtack = ack.sdram_dtack && !hold;
		else
			e.dtack = !hold;
		e.we    = req.as && !req.rw && (ram || sh_wr);
		e.oe    = rd && (ram || sh_rd);
		e.waddr = {1'b0, a[21:1]};
		e.wdata = req.dout;                    // CPU write data straight through
		e.uds   = req.as && req.uds;           // Byte strobes only inside a bus cycle
		e.lds   = req.as && req.lds;
		return e;
	endfunction

	// Shadow switch writes, upper byte only, GoldCard mode only
	always @(posedge clk_sys)
	begin
		if (reset)
			shadow_m <= 1'b0;
		else if (cfg_m == RAM_4096K && cpu_req.as && !cpu_req.rw && cpu_req.uds && !cpu_req.lds)
		begin
			if (({cpu_req.addr, 1'b0} & 24'h7F_FFFF) == 24'h01_C060)
				shadow_m <= 1'b1;
			else if (({cpu_req.addr, 1'b0} & 24'h7F_FFFF) == 24'h01_C064)
				shadow_m <= 1'b0;
		end
	end

	// ========================================
	// Checking
	// ========================================
	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("mismatch %s: got %h expected %h, address %h, test %0d", name, got, exp,
			{cpu_req.addr, 1'b0}, test_no);
	endtask

	task automatic compare_outputs();
		expect_t e;
		e = expected_outputs(cpu_req, cfg_m, ql_mode, shadow_m, src_data, src_ack);
		checks++;
		if (cpu_req.as && cpu_req.rw)
		begin
			assert (cpu_din === e.din)
			else report_mismatch("cpu_din", cpu_din, e.din);
		end
		assert (cpu_dtack === e.dtack)
		else report_mismatch("cpu_dtack", cpu_dtack, e.dtack);
		assert (periph_sel === e.sel)
		else report_mismatch("periph_sel", periph_sel, e.sel);
		assert (sdram_req.we === e.we)
		else report_mismatch("sdram_req.we", sdram_req.we, e.we);
		assert (sdram_req.oe === e.oe)
		else report_mismatch("sdram_req.oe", sdram_req.oe, e.oe);
		assert (sdram_req.addr === e.waddr)
		else report_mismatch("sdram_req.addr", sdram_req.addr, e.waddr);
		assert (sdram_req.din === e.wdata)
		else report_mismatch("sdram_req.din", sdram_req.din, e.wdata);
		assert (sdram_req.uds === e.uds)
		else report_mismatch("sdram_req.uds", sdram_req.uds, e.uds);
		assert (sdram_req.lds === e.lds)
		else report_mismatch("sdram_req.lds", sdram_req.lds, e.lds);
	endtask

	// Sample just before the next rising edge
	initial
	begin
		forever
		begin
			@(posedge clk_sys);
			#17;
			if (check_en)
				compare_outputs();
		end
	end

	initial
	begin
		#TIMEOUT_NS;
		$display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Test failed");
		$finish;
	end

	// ========================================
	// Stimulus
	// ========================================
	task automatic bus_cycle(input logic [23:0] addr, input logic rw, input logic [1:0] ds,
		input logic as);
		@(posedge clk_sys);
		#2;
		cpu_req.addr = addr[23:1];
		cpu_req.as   = as;
		cpu_req.rw   = rw;
		cpu_req.uds  = ds[1];
		cpu_req.lds  = ds[0];
		cpu_req.dout = 16'(rand_bits(16));
		src_data     = {rand_bits(32), rand_bits(32), 16'(rand_bits(16))};
		src_ack      = 3'(rand_bits(3));
	endtask

	task automatic read_cycle(input logic [23:0] addr);
		bus_cycle(addr, 1'b1, 2'b11, 1'b1);
	endtask

	task automatic write_cycle(input logic [23:0] addr, input logic [1:0] ds);
		bus_cycle(addr, 1'b0, ds, 1'b1);
	endtask

	task automatic random_cycles(input int n, input logic [23:0] span);
		logic [23:0] addr;
		logic [1:0]  ds;
		logic        rw;
		repeat (n)
		begin
			addr = 24'(rand_bits(24)) & span;
			ds   = 2'(rand_bits(2));
			rw   = lfsr_step();
			bus_cycle(addr, rw, (ds == 2'b00) ? 2'b11 : ds, 1'b1);
		end
	endtask

	// New RAM size only takes hold through reset
	task automatic pulse_reset(input ram_cfg_e cfg);
		@(posedge clk_sys);
		#2;
		check_en   = 1'b0;
		ram_cfg    = cfg;
		cfg_m      = cfg;
		cpu_req.as = 1'b0;
		rst_req    = 1'b1;
		@(posedge clk_sys);
		#2;
		rst_req = 1'b0;
		wait (!reset);
		#2;
		check_en = 1'b1;
	endtask

	task automatic start_test(input string name);
		test_no++;
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		bus_cycle(24'h00_0000, 1'b1, 2'b00, 1'b0); // Idle, every strobe low
		@(posedge clk_sys);
		if (errors == test_errors)
			$display("test %0d %s: ok", test_no, test_name);
		else
			$display("test %0d %s: FAILED with %0d errors", test_no, test_name,
				errors - test_errors);
	endtask

	initial
	begin
		lfsr     = 32'he901_72ac;
		rst_req  = 1'b0;
		ql_mode  = 1'b1;
		ram_cfg  = RAM_640K;
		cfg_m    = RAM_640K;
		cpu_req  = '0;
		src_data = '0;
		src_ack  = '0;
		check_en = 1'b0;
		errors   = 0;
		checks   = 0;
		test_no  = 0;

		start_test("QL mode reads");
		pulse_reset(RAM_640K);
		read_cycle(24'h00_0000);
		read_cycle(24'h00_4A2E);
		read_cycle(24'h00_C100);              // Extension ROM
		read_cycle(24'h02_0000);
		read_cycle(24'h0A_0000);
		read_cycle(24'h0C_0000);              // Above 640k, open bus
		read_cycle(24'h0E_1234);
		read_cycle(24'h00_FEE4);
		read_cycle(24'h00_FF10);
		random_cycles(8, 24'h0F_FFFE);
		end_test();

		start_test("address wrap");
		for (int i = 0; i < 4; i++)
		begin
			pulse_reset(ram_cfg_e'(i));
			read_cycle(24'h82_0100);          // Aliases to base RAM in every size
			read_cycle(24'hC2_0100);
			write_cycle(24'hF2_3456, 2'b01);
			random_cycles(4, 24'hFF_FFFE);
		end
		end_test();

		start_test("GoldCard boot map");
		pulse_reset(RAM_4096K);
		read_cycle(24'h00_0100);
		read_cycle(24'h00_8000);
		read_cycle(24'h04_0000);
		read_cycle(24'h04_FFFE);
		read_cycle(24'h40_0000);
		read_cycle(24'h40_ABCE);
		write_cycle(24'h00_0200, 2'b11);      // OS copy into SDRAM
		write_cycle(24'h00_1000, 2'b10);
		end_test();

		start_test("ROM shadow switch");
		read_cycle(24'h00_0400);
		write_cycle(24'h01_C060, 2'b11);      // Word write, ignored
		read_cycle(24'h00_0400);
		write_cycle(24'h01_C060, 2'b10);
		read_cycle(24'h00_0400);              // SDRAM from here on
		read_cycle(24'h00_FEE4);
		read_cycle(24'h00_C200);
		write_cycle(24'h00_0400, 2'b11);
		write_cycle(24'h01_C064, 2'b11);
		read_cycle(24'h00_0400);
		write_cycle(24'h01_C064, 2'b10);
		read_cycle(24'h00_0400);              // Boot ROM again
		end_test();

		start_test("I/O decode");
		pulse_reset(RAM_640K);
		read_cycle(24'h01_8000);
		write_cycle(24'h01_8002, 2'b11);
		read_cycle(24'h01_8040);              // Nobody answers, reads zero
		read_cycle(24'h01_BF00);
		write_cycle(24'h01_BF22, 2'b01);
		write_cycle(24'h01_8062, 2'b01);      // ZX8301 control at $18063
		bus_cycle(24'h01_8062, 1'b1, 2'b01, 1'b1);
		bus_cycle(24'h01_8000, 1'b1, 2'b11, 1'b0);
		bus_cycle(24'h01_BF00, 1'b1, 2'b11, 1'b0);
		bus_cycle(24'h02_0000, 1'b0, 2'b11, 1'b0);
		end_test();

		start_test("dtack selection");
		for (int m = 0; m < 2; m++)
		begin
			pulse_reset(RAM_4096K);
			ql_mode = m[0];
			write_cycle(24'h00_0100, 2'b11);
			read_cycle(24'h02_0000);
			read_cycle(24'h01_8000);
			write_cycle(24'h01_C060, 2'b10);
			read_cycle(24'h00_0200);
			read_cycle(24'h00_FEE4);
			random_cycles(6, 24'h0F_FFFE);
		end
		end_test();

		errors = errors + u_dut.u_assert.assert_fails;
		$display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 20 ns clk_sys, reset held for 10 cycles at start and again on request
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 10
)
(
	input  wire logic rst_req,                 // Restarts the reset pulse
	output      logic clk_sys,
	output      logic reset
);

	logic reset_q   = 1'b1;                    // High from time zero
	int   remaining = RESET_CYCLES - 1;        // Edges left with reset high

	initial
	begin
		clk_sys = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_sys = !clk_sys;
	end

	always @(posedge clk_sys)
	begin
		reset_q   <= rst_req || remaining != 0;
		remaining <= rst_req ? RESET_CYCLES - 1 : (remaining != 0 ? remaining - 1 : 0);
	end

	assign reset = reset_q;

endmodule

`default_nettype wire

// File: testbench/ql_bus_assert.sv
/*
 * Bus fabric assertions
 * Strobe qualification, SDRAM and select exclusivity, shadow reset state
 */
`timescale 1ns/1ps
`default_nettype none

module ql_bus_assert import ql_bus_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        reset,
	input  wire cpu_req_t    cpu_req,
	input  wire sdram_req_t  sdram_req,
	input  wire periph_sel_t periph_sel,
	input  wire logic        rom_shadow
);

	int assert_fails = 0;                      // Read by the testbench at the end

	// Nothing moves on the bus while as is low
	strobe_needs_as: assert property (@(posedge clk_sys)
		!cpu_req.as |-> periph_sel == '0 && !sdram_req.we && !sdram_req.oe &&
			!sdram_req.uds && !sdram_req.lds)
	else
	begin
		$error("strobe active while as is low");
		assert_fails++;
	end

	sdram_we_oe: assert property (@(posedge clk_sys) !(sdram_req.we && sdram_req.oe))
	else
	begin
		$error("SDRAM we and oe active together");
		assert_fails++;
	end

	// Mouse page wins over the ZX8302
	io_sel_onehot: assert property (@(posedge clk_sys)
		!(periph_sel.zx8302_sel && periph_sel.qimi_sel))
	else
	begin
		$error("ZX8302 and QIMI selected together");
		assert_fails++;
	end

	shadow_after_reset: assert property (@(posedge clk_sys) reset |=> !rom_shadow)
	else
	begin
		$error("ROM shadow still on after reset");
		assert_fails++;
	end

endmodule

bind ql_bus_fabric ql_bus_assert u_assert
(
	.clk_sys    (clk_sys),
	.reset      (reset),
	.cpu_req    (cpu_req),
	.sdram_req  (sdram_req),
	.periph_sel (periph_sel),
	.rom_shadow (rom_shadow)
);

`default_nettype wire

// File: design/ql_bus_fabric.sv
/*
 * QL bus fabric top level
 * Address decode and shadow control feeding the bus multiplexer
 */
`timescale 1ns/1ps
`default_nettype none

module ql_bus_fabric import ql_bus_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        reset,
	input  wire ram_cfg_e    ram_cfg,
	input  wire logic        ql_mode,      // Original QL CPU speed
	input  wire cpu_req_t    cpu_req,
	input  wire src_data_t   src_data,
	input  wire src_ack_t    src_ack,
	output      logic [15:0] cpu_din,
	output      logic        cpu_dtack,
	output      sdram_req_t  sdram_req,
	output      periph_sel_t periph_sel
);

	ql_region_t region;
	logic       rom_shadow;
	logic       shadow_read;
	logic       shadow_write;

	ql_addr_decode u_decode
	(
		.clk_sys (clk_sys),
		.reset   (reset),
		.ram_cfg (ram_cfg),
		.cpu_req (cpu_req),
		.region  (region)
	);

	// Same bus cycle as the decoder, reuses its GC I/O hit
	gc_shadow_ctrl u_shadow
	(
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_req      (cpu_req),
		.region       (region),
		.rom_shadow   (rom_shadow),
		.shadow_read  (shadow_read),
		.shadow_write (shadow_write)
	);

	ql_bus_mux u_mux
	(
		.cpu_req      (cpu_req),
		.ql_mode      (ql_mode),
		.region       (region),
		.rom_shadow   (rom_shadow),
		.shadow_read  (shadow_read),
		.shadow_write (shadow_write),
		.src_data     (src_data),
		.src_ack      (src_ack),
		.cpu_din      (cpu_din),
		.sdram_req    (sdram_req),
		.cpu_dtack    (cpu_dtack),
		.periph_sel   (periph_sel)
	);

endmodule

`default_nettype wire

// File: design/ql_bus_mux.sv
/*
 * QL bus multiplexer
 * CPU read data and dtack selection, SDRAM request and peripheral strobes
 */
`timescale 1ns/1ps
`default_nettype none

module ql_bus_mux import ql_bus_pkg::*;
(
	input  wire cpu_req_t     cpu_req,
	input  wire logic         ql_mode,
	input  wire ql_region_t   region,
	input  wire logic         rom_shadow,
	input  wire logic         shadow_read,
	input  wire logic         shadow_write,
	input  wire src_data_t    src_data,
	input  wire src_ack_t     src_ack,
	output      logic [15:0]  cpu_din,
	output      sdram_req_t   sdram_req,
	output      logic         cpu_dtack,
	output      periph_sel_t  periph_sel
);

	logic              io;                     // Read or write with strobes
	logic              qlsd_en;
	logic              qlsd_rd;
	logic              qlsd_sel;
	logic              qimi_sel;
	logic              zx8302_sel;
	logic              ram_delay;              // Contention, only in QL mode
	logic [DATA_W-1:0] qlsd_word;
	logic [DATA_W-1:0] io_dout;
	logic [DATA_W-1:0] ql_dout;
	logic [DATA_W-1:0] gc_dout_boot;
	logic [DATA_W-1:0] gc_dout_shadow;

	assign io = region.rd || region.wr;

	// QL-SD hidden under the GC boot ROM until the shadow is on
	assign qlsd_en  = !region.gc_en || rom_shadow;
	assign qlsd_rd  = qlsd_en && region.qlsd_rd;
	assign qlsd_sel = qlsd_en && (region.qlsd_reg || region.qlsd_dat);

	// ========================================
	// Peripheral selects
	// ========================================
	assign qimi_sel   = io && region.ql_io && region.addr[13:8] == 6'h3F; // $1bfxx
	assign zx8302_sel = io && region.ql_io && !region.addr[6] && !qimi_sel; // Mouse wins

	always_comb
	begin
		periph_sel            = '0;
		periph_sel.zx8302_sel = zx8302_sel;
		periph_sel.qimi_sel   = qimi_sel;
		periph_sel.qlsd_sel   = qlsd_sel;
		// MC_STAT, write only at $18063
		periph_sel.zx8301_ce  = region.ql_io && region.wr && cpu_req.lds &&
			{region.addr[6:5], region.addr[1]} == 3'b111;
		periph_sel.vram_wr    = region.wr && region.addr[23:16] == VRAM_BANK;
	end

	// ========================================
	// Read data
	// ========================================
	assign qlsd_word = {src_data.qlsd, src_data.qlsd};

	assign io_dout =
		qimi_sel   ? {src_data.qimi, src_data.qimi} :
		zx8302_sel ? src_data.zx8302 :
		'0;

	assign ql_dout =
		qlsd_rd    ? qlsd_word :
		region.rom ? src_data.ql_rom :         // OS plus ext ROM
		region.ram ? src_data.sdram :
		OPEN_BUS;

	// Shadow off, boot ROM everywhere low
	assign gc_dout_boot =
		region.rom         ? src_data.gc_rom :
		region.gc_boot_rom ? src_data.gc_rom :
		region.gc_os_rom   ? src_data.ql_rom :
		region.ram         ? src_data.sdram :
		OPEN_BUS;

	assign gc_dout_shadow =
		region.os_rom    ? src_data.sdram :    // Shadow RAM
		qlsd_rd          ? qlsd_word :
		region.ext_rom   ? src_data.ql_rom :
		region.gc_os_rom ? src_data.ql_rom :
		region.ram       ? src_data.sdram :
		OPEN_BUS;

	always_comb
	begin
		if (region.ql_io)
			cpu_din = io_dout;                 // I/O mapped in both modes
		else if (region.gc_en)
			cpu_din = rom_shadow ? gc_dout_shadow : gc_dout_boot;
		else
			cpu_din = ql_dout;
	end

	// ========================================
	// dtack
	// ========================================
	assign ram_delay = ql_mode && src_ack.ram_delay_dtack;

	always_comb
	begin
		if (qlsd_sel)
			cpu_dtack = src_ack.qlsd_dtack;
		else if (shadow_read || shadow_write)
			cpu_dtack = src_ack.sdram_dtack;
		else if (region.ram)
			cpu_dtack = src_ack.sdram_dtack && !ram_delay;
		else
			cpu_dtack = !ram_delay;            // 1 outside QL mode
	end

	// ========================================
	// SDRAM request
	// ========================================
	always_comb
	begin
		sdram_req      = '0;
		sdram_req.addr = {1'b0, region.addr[21:1]};                   // Word address
		sdram_req.din  = cpu_req.dout;
		sdram_req.we   = cpu_req.as && !cpu_req.rw && (region.ram || shadow_write);
		sdram_req.oe   = region.rd && (region.ram || shadow_read);
		sdram_req.uds  = cpu_req.as && cpu_req.uds;
		sdram_req.lds  = cpu_req.as && cpu_req.lds;
	end

endmodule

`default_nettype wire

// File: design/gc_shadow_ctrl.sv
/*
 * GoldCard ROM shadow control
 * Shadow enable register and the shadow read and write qualifiers
 */
`timescale 1ns/1ps
`default_nettype none

module gc_shadow_ctrl import ql_bus_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire cpu_req_t   cpu_req,
	input  wire ql_region_t region,
	output      logic       rom_shadow,
	output      logic       shadow_read,
	output      logic       shadow_write
);

	logic reg_wr;                              // Upper byte write to the GC I/O page

	assign reg_wr = region.gc_io && region.wr && cpu_req.uds && !cpu_req.lds;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			rom_shadow <= 1'b0;                // Boot mapping after reset
		else if (reg_wr)
		begin
			if (region.addr[7:0] == SHADOW_ON_OFS)
				rom_shadow <= 1'b1;            // Shadow RAM on
			else if (region.addr[7:0] == SHADOW_OFF_OFS)
				rom_shadow <= 1'b0;            // Back to boot ROM
		end
	end

	// OS ROM area served from SDRAM once shadowed
	assign shadow_read = region.rd && region.os_rom && rom_shadow;

	// Copying the OS into SDRAM while still running from boot ROM
	// Any write cycle counts, strobes or not
	assign shadow_write = cpu_req.as && !cpu_req.rw && region.os_rom && !rom_shadow;

endmodule

`default_nettype wire

// File: design/ql_addr_decode.sv
/*
 * QL address decoder
 * Wraps the CPU address by RAM size and decodes regions and cycle kind
 */
`timescale 1ns/1ps
`default_nettype none

module ql_addr_decode import ql_bus_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire ram_cfg_e   ram_cfg,
	input  wire cpu_req_t   cpu_req,
	output      ql_region_t region
);

	ram_cfg_e          ram_cfg_q;              // Size as seen at reset
	logic [ADDR_W-1:0] wrap_mask;
	logic [ADDR_W-1:0] a;                      // Wrapped address
	logic              gc_en;
	logic              rd;
	logic              wr;
	logic              bram;
	logic              xram;
	logic              gc_io;
	logic              gc_ram1;
	logic              gc_ram2;
	logic              rom;
	logic              ext_rom;

	// Size change only takes effect through a reset
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			ram_cfg_q <= ram_cfg;
	end

	always_comb
	begin
		unique case (ram_cfg_q)
			RAM_128K:  wrap_mask = WRAP_MASK_128K;
			RAM_640K,
			RAM_896K:  wrap_mask = WRAP_MASK_1M;
			default:   wrap_mask = WRAP_MASK_8M;
		endcase
	end

	// A0 high only on a lower byte access
	assign a     = {cpu_req.addr, !cpu_req.uds && cpu_req.lds} & wrap_mask;
	assign gc_en = ram_cfg_q == RAM_4096K;

	// ========================================
	// Cycle kind
	// ========================================
	assign rd = cpu_req.as &&  cpu_req.rw && (cpu_req.uds || cpu_req.lds);
	assign wr = cpu_req.as && !cpu_req.rw && (cpu_req.uds || cpu_req.lds);

	// ========================================
	// RAM
	// ========================================
	assign bram = a[23:17] == 7'h01;           // 128k base RAM $20000-$3ffff

	// Extended RAM above $40000, size dependent
	always_comb
	begin
		unique case (ram_cfg_q)
			RAM_640K:  xram = (a[23:20] == 4'h0) && ^a[19:18]; // $40000-$bffff
			RAM_896K:  xram = (a[23:20] == 4'h0) && |a[19:18]; // $40000-$fffff
			RAM_4096K: xram = (a[23:22] == 2'b00) && |a[21:18]; // up to $3fffff
			default:   xram = 1'b0;
		endcase
	end

	assign gc_io   = gc_en && a[23:8] == GC_IO_BASE[23:8];
	assign gc_ram1 = gc_en && a[23:15] == GC_RAM1_BASE[23:15];
	assign gc_ram2 = gc_en && a[23:14] == GC_RAM2_BASE[23:14] && !gc_io; // Skips the I/O page

	// ========================================
	// ROM
	// ========================================
	assign rom     = a[23:16] == 8'h00;                    // Lower 64k
	assign ext_rom = a[23:14] == EXT_ROM_BASE[23:14];

	always_comb
	begin
		region             = '0;
		region.addr        = a;
		region.rd          = rd;
		region.wr          = wr;
		region.gc_en       = gc_en;
		region.ql_io       = a[23:14] == QL_IO_BASE[23:14]; // $18000-$1bfff
		region.ram         = bram || xram || gc_ram1 || gc_ram2;
		region.rom         = rom;
		region.ext_rom     = ext_rom;
		region.os_rom      = rom && !ext_rom;               // $0000-$bfff
		region.gc_io       = gc_io;
		region.gc_boot_rom = gc_en && a[23:16] == GC_BOOT_ROM_BASE[23:16];
		region.gc_os_rom   = gc_en && a[23:16] == GC_OS_ROM_BASE[23:16];

		// QL-SD sits in the ROM slot, reads only
		region.qlsd_reg = rom && rd &&
			(a[15:4] == 12'hFEE || a[15:4] == 12'hFEF);
		region.qlsd_rd  = rom && rd && a[15:0] == QLSD_READ_ADDR;
		region.qlsd_dat = rom && rd && a[15:8] == 8'hFF;       // Data window
	end

endmodule

`default_nettype wire

// File: design/ql_bus_pkg.sv
/*
 * QL bus fabric package
 * Bus widths, memory map constants, RAM size encoding and bus structs
 */
`default_nettype none

package ql_bus_pkg;

	// ========================================
	// Widths
	// ========================================
	localparam int ADDR_W    = 24;             // 68000 address space
	localparam int DATA_W    = 16;             // CPU data bus
	localparam int SDRAM_AW  = 22;             // SDRAM word address

	// ========================================
	// Memory map
	// ========================================
	localparam logic [ADDR_W-1:0] QL_IO_BASE       = 24'h01_8000; // 16k internal I/O
	localparam logic [ADDR_W-1:0] GC_IO_BASE       = 24'h01_C000; // 256 byte GoldCard I/O page
	localparam logic [ADDR_W-1:0] GC_RAM1_BASE     = 24'h01_0000; // 32k extra RAM
	localparam logic [ADDR_W-1:0] GC_RAM2_BASE     = 24'h01_C000; // 16k extra RAM, minus the I/O page
	localparam logic [ADDR_W-1:0] GC_BOOT_ROM_BASE = 24'h04_0000; // Second boot ROM copy
	localparam logic [ADDR_W-1:0] GC_OS_ROM_BASE   = 24'h40_0000; // Original OS ROM copy
	localparam logic [ADDR_W-1:0] EXT_ROM_BASE     = 24'h00_C000; // 16k extension ROM slot
	localparam logic [7:0]        VRAM_BANK        = 8'h02;       // Screen memory, A23..A16

	// Shadow switch registers, low byte inside the GoldCard I/O page
	localparam logic [7:0] SHADOW_ON_OFS  = 8'h60;
	localparam logic [7:0] SHADOW_OFF_OFS = 8'h64;

	// Only QL-SD register that drives data back
	localparam logic [15:0] QLSD_READ_ADDR = 16'hFEE4;

	// Address wrap masks
	localparam logic [ADDR_W-1:0] WRAP_MASK_128K = 24'h03_FFFF; // 256k space
	localparam logic [ADDR_W-1:0] WRAP_MASK_1M   = 24'h0F_FFFF; // 640k and 896k
	localparam logic [ADDR_W-1:0] WRAP_MASK_8M   = 24'h7F_FFFF; // 4M RAM plus extended I/O

	localparam logic [DATA_W-1:0] OPEN_BUS = 16'hFFFF;          // Nothing answers

	// ========================================
	// Types
	// ========================================
	typedef enum logic [1:0]
	{
		RAM_128K  = 2'b00,
		RAM_640K  = 2'b01,
		RAM_896K  = 2'b10,
		RAM_4096K = 2'b11                      // Also selects GoldCard mode
	} ram_cfg_e;

	// Raw CPU bus cycle, strobes active high
	typedef struct packed
	{
		logic [ADDR_W-1:1] addr;               // A0 comes from the strobes
		logic              as;
		logic              rw;                 // 1 = read
		logic              uds;
		logic              lds;
		logic [DATA_W-1:0] dout;               // Write data
	} cpu_req_t;

	// Decoded cycle
	typedef struct packed
	{
		logic [ADDR_W-1:0] addr;               // Wrapped address
		logic              rd;
		logic              wr;
		logic              ql_io;
		logic              ram;                // Any RAM incl. GoldCard RAM
		logic              rom;
		logic              ext_rom;
		logic              os_rom;
		logic              gc_io;
		logic              gc_boot_rom;
		logic              gc_os_rom;
		logic              qlsd_reg;           // Not yet qualified by shadow state
		logic              qlsd_rd;
		logic              qlsd_dat;
		logic              gc_en;
	} ql_region_t;

	typedef struct packed
	{
		logic [DATA_W-1:0] ql_rom;
		logic [DATA_W-1:0] gc_rom;
		logic [DATA_W-1:0] sdram;
		logic [DATA_W-1:0] zx8302;
		logic [7:0]        qimi;
		logic [7:0]        qlsd;
	} src_data_t;

	typedef struct packed
	{
		logic sdram_dtack;
		logic qlsd_dtack;
		logic ram_delay_dtack;                 // QL contention, high = hold off
	} src_ack_t;

	typedef struct packed
	{
		logic [SDRAM_AW-1:0] addr;             // Word address
		logic [DATA_W-1:0]   din;
		logic                we;
		logic                oe;
		logic                uds;
		logic                lds;
	} sdram_req_t;

	typedef struct packed
	{
		logic zx8302_sel;
		logic qimi_sel;
		logic qlsd_sel;
		logic zx8301_ce;
		logic vram_wr;
	} periph_sel_t;

endpackage

`default_nettype wire
